// ==== include/rp_defs.svh ====
// bus, sample, region and pwm geometry constants
// housekeeping id word

`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

// system bus
`define RP_BUS_AW      32
`define RP_BUS_DW      32
`define RP_SEL_W       4            // one select per byte

// analog data path
`define RP_ADC_PIN_W   14           // pin word, reserved lsbs already stripped
`define RP_SMP_W       14           // signed sample

// region field of the bus address, 1 MB per region
`define RP_REGION_LSB  20
`define RP_REGION_MSB  22
`define RP_N_REGION    8

// housekeeping
`define RP_HK_ID       32'h5250_0001  // "RP" + revision
`define RP_LED_W       8

// slow pwm dac
`define RP_N_PWM       4
`define RP_PWM_CFG_W   24           // duty in [23:16], dither mask in [15:0]
`define RP_PWM_STEPS   256          // adc_clk cycles per period
`define RP_PWM_DITHER  16           // periods per dither cycle

`endif

// ==== verilog/rp_pkg.sv ====
// shared types: sample word, bus regions, register offsets

`include "rp_defs.svh"

package rp_pkg;

  // two's complement sample as seen inside the fabric
  typedef logic signed [`RP_SMP_W-1:0] rp_sample_t;

  // address bits 22..20
  typedef enum logic [`RP_REGION_MSB-`RP_REGION_LSB:0] {
    RGN_HK  = 3'd0,     // housekeeping
    RGN_AMS = 3'd4      // pwm config
  } rp_region_e;

  // housekeeping byte offsets
  typedef enum logic [7:0] {
    HK_ID    = 8'h00,
    HK_LED   = 8'h04,
    HK_LOOP  = 8'h08,
    HK_DAC_A = 8'h0C,
    HK_DAC_B = 8'h10,
    HK_ADC_A = 8'h14,   // read only
    HK_ADC_B = 8'h18    // read only
  } rp_hk_reg_e;

  // ams byte offsets, one word per pwm channel
  typedef enum logic [7:0] {
    PWM_CFG0 = 8'h20,
    PWM_CFG1 = 8'h24,
    PWM_CFG2 = 8'h28,
    PWM_CFG3 = 8'h2C
  } rp_ams_reg_e;

endpackage

// ==== verilog/rp_sys_decoder.sv ====
// system bus region decoder, response mux, default slave for unmapped regions

`timescale 1ns/10ps
`include "rp_defs.svh"

module rp_sys_decoder import rp_pkg::*; (
  input  logic                                    adc_clk,     // checker clock
  input  logic                                    arst_n_i,
  input  logic [`RP_BUS_AW-1:0]                   sys_addr_i,
  input  logic                                    sys_wen_i,
  input  logic                                    sys_ren_i,
  input  logic [1:0][`RP_BUS_DW-1:0]              rdata_i,     // [0] hk, [1] ams
  input  logic [1:0]                              ack_i,
  input  logic [1:0]                              err_i,
  output logic [`RP_N_REGION-1:0]                 wen_o,
  output logic [`RP_N_REGION-1:0]                 ren_o,
  output logic [`RP_BUS_DW-1:0]                   sys_rdata_o,
  output logic                                    sys_ack_o,
  output logic                                    sys_err_o
);

  localparam int         RW          = `RP_REGION_MSB - `RP_REGION_LSB + 1;
  localparam rp_region_e MAP_RGN [2] = '{RGN_HK, RGN_AMS};  // slave port -> region

  logic [RW-1:0]                           rgn;
  logic [`RP_N_REGION-1:0]                 cs;          // one-hot select
  logic                                    strb;
  logic [`RP_N_REGION-1:0][`RP_BUS_DW-1:0] tab_rdata;
  logic [`RP_N_REGION-1:0]                 tab_ack;
  logic [`RP_N_REGION-1:0]                 tab_err;

  assign rgn   = sys_addr_i[`RP_REGION_MSB:`RP_REGION_LSB];
  assign cs    = `RP_N_REGION'(1) << rgn;
  assign strb  = sys_wen_i | sys_ren_i;
  assign wen_o = cs & {`RP_N_REGION{sys_wen_i}};
  assign ren_o = cs & {`RP_N_REGION{sys_ren_i}};

  // response table, unmapped entries answer in the strobe cycle
  always_comb
  begin
    for (int r = 0; r < `RP_N_REGION; r++)
    begin
      tab_rdata[r] = '0;
      tab_ack[r]   = strb;
      tab_err[r]   = 1'b0;
    end
    for (int m = 0; m < 2; m++)
    begin
      tab_rdata[MAP_RGN[m]] = rdata_i[m];
      tab_ack[MAP_RGN[m]]   = ack_i[m];
      tab_err[MAP_RGN[m]]   = err_i[m];
    end
  end

  assign sys_rdata_o = tab_rdata[rgn];  // address held until ack
  assign sys_ack_o   = tab_ack[rgn];
  assign sys_err_o   = tab_err[rgn];

  // no spurious ack, mapped slaves answer one cycle late
  a_ack_has_strobe: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    $rose(sys_ack_o) |-> strb || $past(strb))
    else $error("bus ack without strobe");

endmodule

// ==== verilog/rp_hk.sv ====
// housekeeping slave: id, leds, digital loop, dac set values, adc capture

`timescale 1ns/10ps
`include "rp_defs.svh"

module rp_hk import rp_pkg::*; (
  input  logic                    adc_clk,
  input  logic                    arst_n_i,
  input  logic [`RP_BUS_AW-1:0]   sys_addr_i,
  input  logic [`RP_BUS_DW-1:0]   sys_wdata_i,
  input  logic [`RP_SEL_W-1:0]    sys_sel_i,
  input  logic                    wen_i,
  input  logic                    ren_i,
  input  rp_sample_t              adc_a_i,
  input  rp_sample_t              adc_b_i,
  output logic [`RP_BUS_DW-1:0]   rdata_o,
  output logic                    ack_o,
  output logic                    err_o,
  output logic [`RP_LED_W-1:0]    led_o,
  output logic                    digital_loop_o,
  output rp_sample_t              dac_a_o,
  output rp_sample_t              dac_b_o
);

  localparam int XW = `RP_BUS_DW - `RP_SMP_W;  // sign extension bits

  logic [`RP_LED_W-1:0]  led_q;
  logic                  loop_q;
  rp_sample_t            dac_a_q, dac_b_q;
  rp_sample_t            adc_a_q, adc_b_q;   // captured every cycle
  logic [`RP_BUS_DW-1:0] rd_mux;

  always_ff @(posedge adc_clk)
  begin
    adc_a_q <= adc_a_i;
    adc_b_q <= adc_b_i;
  end

  //////////////////////////////
  // byte masked writes
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      led_q   <= '0;
      loop_q  <= 1'b0;
      dac_a_q <= '0;        // signed zero, mid scale on the pins
      dac_b_q <= '0;
    end
    else if (wen_i)
    begin
      case (sys_addr_i[7:0])
        HK_LED:   if (sys_sel_i[0]) led_q <= sys_wdata_i[`RP_LED_W-1:0];
        HK_LOOP:  if (sys_sel_i[0]) loop_q <= sys_wdata_i[0];
        HK_DAC_A:
        begin
          if (sys_sel_i[0]) dac_a_q[7:0] <= sys_wdata_i[7:0];
          if (sys_sel_i[1]) dac_a_q[`RP_SMP_W-1:8] <= sys_wdata_i[`RP_SMP_W-1:8];
        end
        HK_DAC_B:
        begin
          if (sys_sel_i[0]) dac_b_q[7:0] <= sys_wdata_i[7:0];
          if (sys_sel_i[1]) dac_b_q[`RP_SMP_W-1:8] <= sys_wdata_i[`RP_SMP_W-1:8];
        end
        default: ;          // id and adc words are read only
      endcase
    end
  end

  always_comb
  begin
    case (sys_addr_i[7:0])
      HK_ID:    rd_mux = `RP_HK_ID;
      HK_LED:   rd_mux = {{(`RP_BUS_DW-`RP_LED_W){1'b0}}, led_q};
      HK_LOOP:  rd_mux = {{(`RP_BUS_DW-1){1'b0}}, loop_q};
      HK_DAC_A: rd_mux = {{XW{dac_a_q[`RP_SMP_W-1]}}, dac_a_q};
      HK_DAC_B: rd_mux = {{XW{dac_b_q[`RP_SMP_W-1]}}, dac_b_q};
      HK_ADC_A: rd_mux = {{XW{adc_a_q[`RP_SMP_W-1]}}, adc_a_q};
      HK_ADC_B: rd_mux = {{XW{adc_b_q[`RP_SMP_W-1]}}, adc_b_q};
      default:  rd_mux = '0;   // unknown offset
    endcase
  end

  //////////////////////////////
  // response, one cycle after strobe
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      ack_o <= 1'b0;
    else
      ack_o <= wen_i | ren_i;
  end

  always_ff @(posedge adc_clk)
    rdata_o <= ren_i ? rd_mux : '0;

  assign err_o          = 1'b0;
  assign led_o          = led_q;
  assign digital_loop_o = loop_q;
  assign dac_a_o        = dac_a_q;
  assign dac_b_o        = dac_b_q;

  // strobe answered in the next cycle with no overlapping access
  a_hk_ack: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (wen_i || ren_i) |=> ack_o && !(wen_i || ren_i))
    else $error("hk strobe not answered alone in the next cycle");

endmodule

// ==== verilog/rp_analog_io.sv ====
// adc input register and code conversion with digital loop, dac output register

`timescale 1ns/10ps
`include "rp_defs.svh"

module rp_analog_io import rp_pkg::*; (
  input  logic                      adc_clk,
  input  logic                      arst_n_i,
  input  logic [`RP_ADC_PIN_W-1:0]  adc_dat_a_i,
  input  logic [`RP_ADC_PIN_W-1:0]  adc_dat_b_i,
  input  logic                      digital_loop_i,
  input  rp_sample_t                dac_a_i,
  input  rp_sample_t                dac_b_i,
  output rp_sample_t                adc_a_o,
  output rp_sample_t                adc_b_o,
  output logic [`RP_SMP_W-1:0]      dac_dat_a_o,
  output logic [`RP_SMP_W-1:0]      dac_dat_b_o
);

  logic [`RP_ADC_PIN_W-1:0] adc_a_q, adc_b_q;  // pin registers

  // negative slope offset binary <-> two's complement, same rule both ways
  function automatic logic [`RP_SMP_W-1:0] neg_slope(input logic [`RP_SMP_W-1:0] v);
    return {v[`RP_SMP_W-1], ~v[`RP_SMP_W-2:0]};
  endfunction

  always_ff @(posedge adc_clk)
  begin
    adc_a_q <= adc_dat_a_i;
    adc_b_q <= adc_dat_b_i;
  end

  // loop path bypasses the pin register
  assign adc_a_o = digital_loop_i ? dac_a_i : neg_slope(adc_a_q);
  assign adc_b_o = digital_loop_i ? dac_b_i : neg_slope(adc_b_q);

  //////////////////////////////
  // dac output registers
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_dat_a_o <= neg_slope('0);  // code of signed zero
      dac_dat_b_o <= neg_slope('0);
    end
    else
    begin
      dac_dat_a_o <= neg_slope(dac_a_i);
      dac_dat_b_o <= neg_slope(dac_b_i);
    end
  end

endmodule

// ==== verilog/rp_ams.sv ====
// pwm configuration slave, four 24-bit words

`timescale 1ns/10ps
`include "rp_defs.svh"

module rp_ams import rp_pkg::*; (
  input  logic                                     adc_clk,
  input  logic                                     arst_n_i,
  input  logic [`RP_BUS_AW-1:0]                    sys_addr_i,
  input  logic [`RP_BUS_DW-1:0]                    sys_wdata_i,
  input  logic [`RP_SEL_W-1:0]                     sys_sel_i,
  input  logic                                     wen_i,
  input  logic                                     ren_i,
  output logic [`RP_BUS_DW-1:0]                    rdata_o,
  output logic                                     ack_o,
  output logic                                     err_o,
  output logic [`RP_N_PWM-1:0][`RP_PWM_CFG_W-1:0]  pwm_cfg_o
);

  localparam int IW = $clog2(`RP_N_PWM);
  localparam int NB = `RP_PWM_CFG_W / 8;     // writable bytes per word

  logic [`RP_N_PWM-1:0][`RP_PWM_CFG_W-1:0] cfg_q;
  logic                                    hit;  // offset maps to a word
  logic [IW-1:0]                           idx;

  always_comb
  begin
    hit = 1'b1;
    idx = '0;
    case (sys_addr_i[7:0])
      PWM_CFG0: idx = IW'(0);
      PWM_CFG1: idx = IW'(1);
      PWM_CFG2: idx = IW'(2);
      PWM_CFG3: idx = IW'(3);
      default:  hit = 1'b0;
    endcase
  end

  //////////////////////////////
  // config words and response
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cfg_q <= '0;          // all channels idle low
      ack_o <= 1'b0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;
      if (wen_i && hit)
        for (int b = 0; b < NB; b++)
          if (sys_sel_i[b]) cfg_q[idx][b*8 +: 8] <= sys_wdata_i[b*8 +: 8];
    end
  end

  always_ff @(posedge adc_clk)
    rdata_o <= (ren_i && hit) ? {{(`RP_BUS_DW-`RP_PWM_CFG_W){1'b0}}, cfg_q[idx]} : '0;

  assign err_o     = 1'b0;
  assign pwm_cfg_o = cfg_q;

endmodule

// ==== verilog/rp_pwm.sv ====
// dithered pwm channel, duty in cfg[23:16], per-period dither mask in cfg[15:0]

`timescale 1ns/10ps
`include "rp_defs.svh"

module rp_pwm (
  input  logic                      adc_clk,
  input  logic                      arst_n_i,
  input  logic [`RP_PWM_CFG_W-1:0]  cfg_i,
  output logic                      pwm_o
);

  localparam int SW = $clog2(`RP_PWM_STEPS);    // step counter width
  localparam int PW = $clog2(`RP_PWM_DITHER);   // sub-period counter width

  logic [SW-1:0]              step;
  logic [PW-1:0]              sub;
  logic [`RP_PWM_CFG_W-1:0]   cfg_q;            // stable for a whole period
  logic [SW-1:0]              duty;
  logic [`RP_PWM_DITHER-1:0]  dither;
  logic [SW:0]                thresh;           // one bit wider, 256 fits

  assign duty   = cfg_q[`RP_PWM_CFG_W-1 -: SW];
  assign dither = cfg_q[`RP_PWM_DITHER-1:0];
  assign thresh = {1'b0, duty} + (SW+1)'(dither[sub]);  // extra step when bit set

  //////////////////////////////
  // counters, config latch, output
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      step  <= '0;
      sub   <= '0;
      cfg_q <= '0;
      pwm_o <= 1'b0;
    end
    else
    begin
      step <= step + 1'b1;            // wraps every period
      if (step == '1)
      begin
        sub   <= sub + 1'b1;          // next sub-period
        cfg_q <= cfg_i;               // takes effect at period start
      end
      pwm_o <= {1'b0, step} < thresh;
    end
  end

  // zero duty and clear dither bit keep the period low after its first step
  // output at step 0 still belongs to the previous period
  a_pwm_idle: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (step != '0 && duty == '0 && !dither[sub]) |-> !pwm_o)
    else $error("pwm high with zero duty and clear dither bit");

endmodule

// ==== verilog/rp_top.sv ====
// fast clock core: bus decoder, housekeeping, analog io, ams and pwm channels

`timescale 1ns/10ps
`include "rp_defs.svh"

module rp_top import rp_pkg::*; (
  input  logic                             adc_clk,
  input  logic                             arst_n_i,
  // system bus
  input  logic [`RP_BUS_AW-1:0]            sys_addr_i,
  input  logic [`RP_BUS_DW-1:0]            sys_wdata_i,
  input  logic [`RP_SEL_W-1:0]             sys_sel_i,
  input  logic                             sys_wen_i,
  input  logic                             sys_ren_i,
  output logic [`RP_BUS_DW-1:0]            sys_rdata_o,
  output logic                             sys_ack_o,
  output logic                             sys_err_o,
  // converters
  input  logic [`RP_ADC_PIN_W-1:0]         adc_dat_a_i,
  input  logic [`RP_ADC_PIN_W-1:0]         adc_dat_b_i,
  output logic [`RP_SMP_W-1:0]             dac_dat_a_o,
  output logic [`RP_SMP_W-1:0]             dac_dat_b_o,
  output logic [`RP_N_PWM-1:0]             dac_pwm_o,
  output logic [`RP_LED_W-1:0]             led_o
);

  logic [`RP_N_REGION-1:0]                 rgn_wen;
  logic [`RP_N_REGION-1:0]                 rgn_ren;
  logic [1:0][`RP_BUS_DW-1:0]              slv_rdata;   // [0] hk, [1] ams
  logic [1:0]                              slv_ack;
  logic [1:0]                              slv_err;
  rp_sample_t                              adc_a, adc_b;  // converted adc
  rp_sample_t                              dac_a, dac_b;  // set values
  logic                                    digital_loop;
  logic [`RP_N_PWM-1:0][`RP_PWM_CFG_W-1:0] pwm_cfg;

  //////////////////////////////
  // bus
  rp_sys_decoder i_dec (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i),
    .sys_addr_i (sys_addr_i), .sys_wen_i (sys_wen_i), .sys_ren_i (sys_ren_i),
    .rdata_i (slv_rdata), .ack_i (slv_ack), .err_i (slv_err),
    .wen_o (rgn_wen), .ren_o (rgn_ren),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o (sys_ack_o), .sys_err_o (sys_err_o)
  );

  //////////////////////////////
  // housekeeping + analog path
  rp_hk i_hk (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i),
    .sys_addr_i (sys_addr_i), .sys_wdata_i (sys_wdata_i), .sys_sel_i (sys_sel_i),
    .wen_i (rgn_wen[RGN_HK]), .ren_i (rgn_ren[RGN_HK]),
    .adc_a_i (adc_a), .adc_b_i (adc_b),
    .rdata_o (slv_rdata[0]), .ack_o (slv_ack[0]), .err_o (slv_err[0]),
    .led_o (led_o), .digital_loop_o (digital_loop), .dac_a_o (dac_a), .dac_b_o (dac_b)
  );

  rp_analog_io i_aio (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .digital_loop_i (digital_loop), .dac_a_i (dac_a), .dac_b_i (dac_b),
    .adc_a_o (adc_a), .adc_b_o (adc_b),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o)
  );

  //////////////////////////////
  // slow pwm dac
  rp_ams i_ams (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i),
    .sys_addr_i (sys_addr_i), .sys_wdata_i (sys_wdata_i), .sys_sel_i (sys_sel_i),
    .wen_i (rgn_wen[RGN_AMS]), .ren_i (rgn_ren[RGN_AMS]),
    .rdata_o (slv_rdata[1]), .ack_o (slv_ack[1]), .err_o (slv_err[1]),
    .pwm_cfg_o (pwm_cfg)
  );

  for (genvar i = 0; i < `RP_N_PWM; i++)
  begin : g_pwm
    rp_pwm i_pwm (
      .adc_clk (adc_clk), .arst_n_i (arst_n_i),
      .cfg_i (pwm_cfg[i]), .pwm_o (dac_pwm_o[i])  // straight to pin
    );
  end

endmodule

// ==== include/tb_rp_bus_tasks.svh ====
// bus access tasks, code conversion and expected-value helpers
// error and access counters shared with the testbench top

`ifndef TB_RP_BUS_TASKS_SVH
`define TB_RP_BUS_TASKS_SVH

localparam int ACK_LIMIT = 8;               // cycles before a missing ack counts

int                    err_cnt   = 0;
int                    wr_cnt    = 0;
int                    rd_cnt    = 0;
logic                  rd_pend   = 1'b0;    // read data check armed
logic [`RP_BUS_DW-1:0] exp_rdata = '0;

// region in bits 22..20, register offset in the low byte
function automatic logic [`RP_BUS_AW-1:0] reg_addr(input logic [2:0] rgn,
                                                   input logic [7:0] off);
  return {9'b0, rgn, 12'b0, off};
endfunction

// msb kept, lower 13 bits inverted; the same rule works in both directions
function automatic logic [`RP_SMP_W-1:0] convert_code(input logic [`RP_SMP_W-1:0] v);
  return v ^ 14'h1FFF;
endfunction

function automatic logic [`RP_BUS_DW-1:0] sign_extend(input rp_sample_t s);
  return {{(`RP_BUS_DW-`RP_SMP_W){s[`RP_SMP_W-1]}}, s};
endfunction

// dac set value after a byte masked write
function automatic rp_sample_t merge_sample(input rp_sample_t old,
                                            input logic [31:0] w, input logic [3:0] sel);
  rp_sample_t r;
  r = old;
  if (sel[0]) r[7:0] = w[7:0];
  if (sel[1]) r[13:8] = w[13:8];
  return r;
endfunction

// high steps over one dither cycle: duty per period, plus one where the mask bit is set
function automatic int pwm_high_count(input logic [`RP_PWM_CFG_W-1:0] cfg);
  int n;
  int per;
  n = 0;
  for (int p = 0; p < `RP_PWM_DITHER; p++)
  begin
    per = int'(cfg[23:16]) + int'(cfg[p]);
    n += (per > `RP_PWM_STEPS) ? `RP_PWM_STEPS : per;  // never more than a full period
  end
  return n;
endfunction

task automatic report_mismatch(input string sig, input logic [63:0] got,
                               input logic [63:0] exp);
  err_cnt++;
  $display("[ERROR] %s got %h expected %h", sig, got, exp);
endtask

// one access: strobe for one cycle, address held until ack, then idle cycles
task automatic access_bus(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] sel, input logic is_wr);
  int   waited;
  logic got;
  @(posedge adc_clk);
  #1;
  sys_addr_i  = addr;
  sys_wdata_i = data;
  sys_sel_i   = sel;
  sys_wen_i   = is_wr;
  sys_ren_i   = !is_wr;
  @(negedge adc_clk);
  got = sys_ack_o;                          // unmapped answers in the strobe cycle
  @(posedge adc_clk);
  #1;
  sys_wen_i = 1'b0;
  sys_ren_i = 1'b0;
  waited    = 0;
  while (!got && waited < ACK_LIMIT)
  begin
    @(negedge adc_clk);                     // sample mid cycle
    got = sys_ack_o;
    waited++;
  end
  if (!got)
  begin
    err_cnt++;
    $display("no ack on the bus for address %h within %0d cycles", addr, ACK_LIMIT);
  end
  repeat (2) @(posedge adc_clk);            // room for the dac pin check
  #1;
endtask

task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] sel);
  access_bus(addr, data, sel, 1'b1);
  wr_cnt++;
endtask

task automatic read_word(input logic [31:0] addr, input logic [31:0] exp);
  exp_rdata = exp;
  rd_pend   = 1'b1;
  access_bus(addr, '0, '1, 1'b0);
  rd_pend   = 1'b0;
  rd_cnt++;
endtask

`endif

// ==== test/tb_rp_top.sv ====
// testbench top: clock, reset, watchdog, stimulus sequence, checking assertions

`timescale 1ns/10ps
`include "rp_defs.svh"

module tb_rp_top import rp_pkg::*; ();

  localparam int CLK_NS     = 4;
  localparam int PWM_WIN    = `RP_PWM_STEPS * `RP_PWM_DITHER;   // one dither cycle
  localparam int PWM_ROUNDS = 2;
  localparam int RUN_CYCLES = 2 * (PWM_ROUNDS * (PWM_WIN + 2 * `RP_PWM_STEPS) + 4000);
  localparam logic [2:0] UNMAPPED [6] = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};

  logic                    adc_clk;
  logic                    arst_n_i;
  logic [`RP_BUS_AW-1:0]   sys_addr_i;
  logic [`RP_BUS_DW-1:0]   sys_wdata_i;
  logic [`RP_SEL_W-1:0]    sys_sel_i;
  logic                    sys_wen_i;
  logic                    sys_ren_i;
  logic [`RP_BUS_DW-1:0]   sys_rdata_o;
  logic                    sys_ack_o;
  logic                    sys_err_o;
  logic [`RP_ADC_PIN_W-1:0] adc_dat_a_i, adc_dat_b_i;
  logic [`RP_SMP_W-1:0]    dac_dat_a_o, dac_dat_b_o;
  logic [`RP_N_PWM-1:0]    dac_pwm_o;
  logic [`RP_LED_W-1:0]    led_o;

  logic                    idle_chk;           // post reset window
  logic                    win_on, win_end;    // pwm counting window
  int                      hi_cnt [`RP_N_PWM];
  int                      exp_hi [`RP_N_PWM];
  logic [`RP_LED_W-1:0]    exp_led;
  rp_sample_t              exp_dac_a, exp_dac_b;
  logic                    strobe, mapped, dac_a_wr, dac_b_wr;

  `include "tb_rp_bus_tasks.svh"

  rp_top dut (.*);

  assign strobe   = sys_wen_i | sys_ren_i;
  assign mapped   = sys_addr_i[`RP_REGION_MSB:`RP_REGION_LSB] inside {RGN_HK, RGN_AMS};
  assign dac_a_wr = sys_wen_i && sys_addr_i == reg_addr(RGN_HK, HK_DAC_A);
  assign dac_b_wr = sys_wen_i && sys_addr_i == reg_addr(RGN_HK, HK_DAC_B);

  initial
  begin
    adc_clk = 1'b0;
    forever #(CLK_NS/2) adc_clk = ~adc_clk;
  end

  initial
  begin
    #(RUN_CYCLES * CLK_NS);
    $display("watchdog expired after %0d cycles, run stopped", RUN_CYCLES);
    $display("writes %0d reads %0d errors %0d", wr_cnt, rd_cnt, err_cnt + 1);
    $display("Done: errors found");
    $finish;
  end

  // high steps per channel, cleared while idle, held for the check
  always @(posedge adc_clk)
  begin
    for (int c = 0; c < `RP_N_PWM; c++)
      if (win_on) hi_cnt[c] <= hi_cnt[c] + int'(dac_pwm_o[c]);
      else if (!win_end) hi_cnt[c] <= 0;
  end

  //////////////////////////////
  // checks
  a_reset_state: assert property (@(posedge adc_clk) idle_chk |->
    {sys_ack_o, led_o, dac_pwm_o, dac_dat_a_o, dac_dat_b_o} == {13'h0, 14'h1FFF, 14'h1FFF})
    else report_mismatch("sys_ack_o,led_o,dac_pwm_o,dac_dat_a_o,dac_dat_b_o",
      64'($sampled({sys_ack_o, led_o, dac_pwm_o, dac_dat_a_o, dac_dat_b_o})),
      64'({13'h0, 14'h1FFF, 14'h1FFF}));
  a_ack_not_early: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    strobe && mapped |-> !sys_ack_o)
    else report_mismatch("sys_ack_o", 64'($sampled(sys_ack_o)), 64'h0);
  a_ack_next_cycle: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    $past(strobe && mapped) |-> sys_ack_o)
    else report_mismatch("sys_ack_o", 64'($sampled(sys_ack_o)), 64'h1);
  a_unmapped_answer: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    strobe && !mapped |-> {sys_ack_o, sys_err_o, sys_rdata_o} == {2'b10, 32'h0})
    else report_mismatch("sys_ack_o,sys_err_o,sys_rdata_o",
      64'($sampled({sys_ack_o, sys_err_o, sys_rdata_o})), 64'({2'b10, 32'h0}));
  a_no_error: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    sys_ack_o |-> !sys_err_o)
    else report_mismatch("sys_err_o", 64'($sampled(sys_err_o)), 64'h0);
  a_read_data: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    sys_ack_o && rd_pend |-> sys_rdata_o == exp_rdata)
    else report_mismatch("sys_rdata_o", 64'($sampled(sys_rdata_o)), 64'(exp_rdata));
  a_led: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    sys_ack_o |-> led_o == exp_led)
    else report_mismatch("led_o", 64'($sampled(led_o)), 64'(exp_led));
  a_dac_a_pin: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    $past(dac_a_wr, 2) |-> dac_dat_a_o == convert_code(exp_dac_a))
    else report_mismatch("dac_dat_a_o", 64'($sampled(dac_dat_a_o)),
      64'(convert_code(exp_dac_a)));
  a_dac_b_pin: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    $past(dac_b_wr, 2) |-> dac_dat_b_o == convert_code(exp_dac_b))
    else report_mismatch("dac_dat_b_o", 64'($sampled(dac_dat_b_o)),
      64'(convert_code(exp_dac_b)));

  for (genvar c = 0; c < `RP_N_PWM; c++)
  begin : g_pwm_chk
    a_high_count: assert property (@(posedge adc_clk) win_end |-> hi_cnt[c] == exp_hi[c])
      else report_mismatch($sformatf("dac_pwm_o[%0d] high count", c),
        64'(hi_cnt[c]), 64'(exp_hi[c]));
  end

  //////////////////////////////
  // stimulus
  initial
  begin
    logic [31:0]              w;
    logic [3:0]               sel;
    logic [`RP_PWM_CFG_W-1:0] cfg;
    void'($urandom(32'he595f759));
    {sys_addr_i, sys_wdata_i, sys_sel_i, sys_wen_i, sys_ren_i} = '0;
    {adc_dat_a_i, adc_dat_b_i} = '0;
    {idle_chk, win_on, win_end} = '0;
    {exp_led, exp_dac_a, exp_dac_b} = '0;
    arst_n_i = 1'b0;
    repeat (5) @(posedge adc_clk);
    #1 arst_n_i = 1'b1;
    idle_chk = 1'b1;
    repeat (3) @(posedge adc_clk);
    #1 idle_chk = 1'b0;
    read_word(reg_addr(RGN_HK, HK_ID), `RP_HK_ID);

    // masked register writes with read back
    repeat (16)
    begin
      w = $urandom;
      sel = 4'($urandom);
      if (sel[0]) exp_led = w[7:0];
      write_word(reg_addr(RGN_HK, HK_LED), w, sel);
      read_word(reg_addr(RGN_HK, HK_LED), 32'(exp_led));
      w = $urandom;
      sel = 4'($urandom);
      exp_dac_a = merge_sample(exp_dac_a, w, sel);
      write_word(reg_addr(RGN_HK, HK_DAC_A), w, sel);
      read_word(reg_addr(RGN_HK, HK_DAC_A), sign_extend(exp_dac_a));
      w = $urandom;
      sel = 4'($urandom);
      exp_dac_b = merge_sample(exp_dac_b, w, sel);
      write_word(reg_addr(RGN_HK, HK_DAC_B), w, sel);
      read_word(reg_addr(RGN_HK, HK_DAC_B), sign_extend(exp_dac_b));
    end

    // adc pin codes into the capture registers
    repeat (8)
    begin
      adc_dat_a_i = 14'($urandom);
      adc_dat_b_i = 14'($urandom);
      repeat (3) @(posedge adc_clk);
      read_word(reg_addr(RGN_HK, HK_ADC_A), sign_extend(convert_code(adc_dat_a_i)));
      read_word(reg_addr(RGN_HK, HK_ADC_B), sign_extend(convert_code(adc_dat_b_i)));
    end

    // digital loop, set values replace the adc codes
    write_word(reg_addr(RGN_HK, HK_LOOP), 32'h1, 4'h1);
    repeat (4)
    begin
      exp_dac_a = rp_sample_t'($urandom);
      write_word(reg_addr(RGN_HK, HK_DAC_A), 32'(exp_dac_a), 4'hF);
      read_word(reg_addr(RGN_HK, HK_ADC_A), sign_extend(exp_dac_a));
      exp_dac_b = rp_sample_t'($urandom);
      write_word(reg_addr(RGN_HK, HK_DAC_B), 32'(exp_dac_b), 4'hF);
      read_word(reg_addr(RGN_HK, HK_ADC_B), sign_extend(exp_dac_b));
    end
    write_word(reg_addr(RGN_HK, HK_LOOP), 32'h0, 4'h1);

    // unmapped regions
    foreach (UNMAPPED[i])
    begin
      read_word(reg_addr(UNMAPPED[i], 8'($urandom)), 32'h0);
      write_word(reg_addr(UNMAPPED[i], 8'($urandom)), $urandom, 4'hF);
    end

    // pwm, any full dither cycle after the latch holds every sub-period once
    repeat (PWM_ROUNDS)
    begin
      for (int c = 0; c < `RP_N_PWM; c++)
      begin
        cfg = 24'($urandom);
        exp_hi[c] = pwm_high_count(cfg);
        write_word(reg_addr(RGN_AMS, 8'(PWM_CFG0) + 8'(4 * c)), 32'(cfg), 4'hF);
        read_word(reg_addr(RGN_AMS, 8'(PWM_CFG0) + 8'(4 * c)), 32'(cfg));
      end
      repeat (`RP_PWM_STEPS + 2) @(posedge adc_clk);
      #1 win_on = 1'b1;
      repeat (PWM_WIN) @(posedge adc_clk);
      #1 win_on = 1'b0;
      win_end = 1'b1;
      @(posedge adc_clk);
      #1 win_end = 1'b0;
    end

    repeat (2) @(posedge adc_clk);
    $display("writes %0d reads %0d errors %0d", wr_cnt, rd_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
verilog/rp_pkg.sv
verilog/rp_sys_decoder.sv
verilog/rp_hk.sv
verilog/rp_analog_io.sv
verilog/rp_ams.sv
verilog/rp_pwm.sv
verilog/rp_top.sv
test/tb_rp_top.sv

// ==== Makefile ====
# Verilator lint, simulation and clean for the rp_top core and its testbench

VERILATOR ?= verilator
TOP       ?= tb_rp_top
RTL_TOP   ?= rp_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# a run that stops without either closing message also fails
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not complete"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
